/* tb.f */
+incdir+.
mmc_pkg.sv
mmc_page_if.sv
mmc_fifo.sv
mmc_page_table.sv
mmc_cmd_gen.sv
mmc_dfi_seq.sv
mmc_top.sv
mmc_sva.sv
tb_clk_gen.sv
tb_top.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_top
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_top.sv */
// Testbench top for the memory controller, random reads against a DFI memory and reference model
`timescale 1ns/1ps
`include "mmc_config.svh"

module tb_top
  import mmc_pkg::*;
();

  localparam int NUM_BANKS      = 1 << `MMC_BANK_W;
  localparam int NUM_RANDOM     = 200;
  localparam int NUM_BURST      = 20;
  localparam int HOLD_CYCLES    = 100;
  localparam int TIMEOUT_CYCLES = 400 * (NUM_RANDOM + NUM_BURST) + 200;

  logic       clk;
  logic       reset;
  logic       req_valid;
  bank_t      req_bank;
  page_t      req_page;
  word_t      req_word;
  logic       req_ready;
  logic       resp_valid;
  data_t      resp_data;
  logic       resp_ready = 1'b0;
  logic       dfi_init_done = 1'b0;
  logic       dfi_cs;
  logic [1:0] dfi_cmd;
  logic       dfi_page_phase;
  bank_t      dfi_bank;
  dram_addr_t dfi_addr;
  logic       dfi_rd_valid = 1'b0;
  data_t      dfi_rd_data = '0;

  int cyc = 0;
  int init_at = 32'h7fffffff;
  int seed = 32'hfa8c1976;
  int resp_seed = 32'hfa8c1976 ^ 32'h00005a5a;
  int mem_seed = 32'hfa8c1976 ^ 32'h00a500a5;

  // Reference model of the queued command stream
  logic       model_open [NUM_BANKS];
  page_t      model_page [NUM_BANKS];
  dram_cmd_e  exp_kind [$];
  bank_t      exp_bank [$];
  dram_addr_t exp_addr [$];
  data_t      exp_data [$];

  // DFI memory model
  page_t mem_page [NUM_BANKS];
  data_t rd_data_q [$];
  int    rd_due_q [$];
  int    last_due = 0;

  // Check state
  logic init_seen = 1'b0;
  logic phase_running = 1'b0;
  logic phase_prev = 1'b0;
  logic bp_hold = 1'b0;
  logic saw_req_stall = 1'b0;
  int   err_init = 0;
  int   err_cmd = 0;
  int   err_phase = 0;
  int   err_data = 0;
  int   err_total = 0;
  int   resp_total = 0;
  int   pass_count = 0;
  int   fail_count = 0;

  tb_clk_gen clk_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  mmc_top dut_i (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_bank       (req_bank),
    .req_page       (req_page),
    .req_word       (req_word),
    .req_ready      (req_ready),
    .resp_valid     (resp_valid),
    .resp_data      (resp_data),
    .resp_ready     (resp_ready),
    .dfi_init_done  (dfi_init_done),
    .dfi_cs         (dfi_cs),
    .dfi_cmd        (dfi_cmd),
    .dfi_page_phase (dfi_page_phase),
    .dfi_bank       (dfi_bank),
    .dfi_addr       (dfi_addr),
    .dfi_rd_valid   (dfi_rd_valid),
    .dfi_rd_data    (dfi_rd_data)
  );

  // Memory content rule, a fixed scramble of bank, page and word
  function automatic data_t expected_word(input bank_t b, input page_t p, input word_t w);
    return {p, 4'ha, w, 7'h35, b} ^ 32'h5ca1ab1e;
  endfunction

  // Two pages per bank so hits, misses and conflicts all show up
  function automatic page_t pick_page(input bank_t b, input logic sel);
    return {sel, 8'h5a, b};
  endfunction

  // --------------------------------------------------
  // Reference model and request driver
  // --------------------------------------------------
  task automatic push_expected(input dram_cmd_e k, input bank_t b, input dram_addr_t a);
    exp_kind.push_back(k);
    exp_bank.push_back(b);
    exp_addr.push_back(a);
  endtask

  task automatic model_request(input bank_t b, input page_t p, input word_t w);
    if (!model_open[b])
      push_expected(CMD_OPEN, b, p);
    else if (model_page[b] != p)
    begin
      push_expected(CMD_CLOSE, b, '0);
      push_expected(CMD_OPEN, b, p);
    end
    push_expected(CMD_READ, b, dram_addr_t'(w));
    model_open[b] = 1'b1;
    model_page[b] = p;
    exp_data.push_back(expected_word(b, p, w));
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_request(input bank_t b, input page_t p, input word_t w);
    req_valid = 1'b1;
    req_bank  = b;
    req_page  = p;
    req_word  = w;
    @(negedge clk);
    while (!req_ready)
      @(negedge clk);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    model_request(b, p, w);
  endtask

  task automatic random_request(input logic allow_gap);
    bank_t b;
    logic  sel;
    word_t w;
    b   = bank_t'($random(seed));
    sel = 1'($random(seed));
    w   = word_t'($random(seed));
    send_request(b, pick_page(b, sel), w);
    if (allow_gap && (($random(seed) & 32'h3) == 0))
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while ((exp_data.size() != 0) || (exp_kind.size() != 0))
      @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errors);
    if (errors == 0)
    begin
      pass_count++;
      $display("PASS %s", name);
    end
    else
    begin
      fail_count++;
      $display("FAIL %s with %0d errors", name, errors);
    end
  endtask

  // --------------------------------------------------
  // DFI monitor with the memory model
  // --------------------------------------------------
  task automatic decode_command();
    dram_cmd_e  kind;
    dram_cmd_e  e_kind;
    bank_t      e_bank;
    dram_addr_t e_addr;
    logic       legal;
    int         due;
    legal = 1'b1;
    kind  = CMD_READ;
    if (dfi_page_phase)
    begin
      if (dfi_cmd == `MMC_CODE_OPEN)
        kind = CMD_OPEN;
      else if (dfi_cmd == `MMC_CODE_CLOSE)
        kind = CMD_CLOSE;
      else
        legal = 1'b0;
    end
    else if (dfi_cmd != `MMC_CODE_READ)
      legal = 1'b0;

    if (!legal)
    begin
      $display("Error at %0t ns: command code %b not allowed in phase %b",
               $time, dfi_cmd, dfi_page_phase);
      err_phase++;
      err_total++;
    end
    else
    begin
      if (kind == CMD_OPEN)
        mem_page[dfi_bank] = dfi_addr;
      else if (kind == CMD_READ)
      begin
        // Read data returns in order after 2 to 6 cycles
        due = cyc + 2 + int'($unsigned($random(mem_seed)) % 5);
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        rd_due_q.push_back(due);
        rd_data_q.push_back(expected_word(dfi_bank, mem_page[dfi_bank], word_t'(dfi_addr)));
      end

      if (exp_kind.size() == 0)
      begin
        $display("Unexpected DFI command at %0t ns while no request was waiting", $time);
        err_cmd++;
        err_total++;
      end
      else
      begin
        e_kind = exp_kind.pop_front();
        e_bank = exp_bank.pop_front();
        e_addr = exp_addr.pop_front();
        // Close and read share a code, so the phase is checked against the expected kind
        if ((e_kind == CMD_READ) == dfi_page_phase)
        begin
          $display("Error at %0t ns: %s issued with dfi_page_phase %b",
                   $time, e_kind.name(), dfi_page_phase);
          err_phase++;
          err_total++;
        end
        if ((kind != e_kind) || (dfi_bank != e_bank) ||
            ((kind != CMD_CLOSE) && (dfi_addr != e_addr)))
        begin
          $display("Error at %0t ns: command expected %s bank %0d addr %h, got %s bank %0d addr %h",
                   $time, e_kind.name(), e_bank, e_addr, kind.name(), dfi_bank, dfi_addr);
          err_cmd++;
          err_total++;
        end
      end
    end
  endtask

  task automatic check_response();
    data_t e;
    resp_total++;
    if (exp_data.size() == 0)
    begin
      $display("Response at %0t ns arrived with no request outstanding", $time);
      err_data++;
      err_total++;
    end
    else
    begin
      e = exp_data.pop_front();
      if (resp_data !== e)
      begin
        $display("Error at %0t ns: response expected %h received %h", $time, e, resp_data);
        err_data++;
        err_total++;
      end
    end
  endtask

  // Outputs sampled mid-cycle where they are stable
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (dfi_cs && !init_seen)
      begin
        $display("Error at %0t ns: dfi_cs high before dfi_init_done", $time);
        err_init++;
        err_total++;
      end
      if (!init_seen && dfi_page_phase)
      begin
        $display("Error at %0t ns: page phase high before dfi_init_done", $time);
        err_init++;
        err_total++;
      end
      if (dfi_init_done)
        init_seen = 1'b1;
      if (phase_running && (dfi_page_phase == phase_prev))
      begin
        $display("Error at %0t ns: dfi_page_phase did not toggle", $time);
        err_phase++;
        err_total++;
      end
      if (dfi_page_phase)
        phase_running = 1'b1;
      phase_prev = dfi_page_phase;
      if (dfi_cs)
        decode_command();
      if (resp_valid && resp_ready)
        check_response();
      if (bp_hold && !req_ready)
        saw_req_stall = 1'b1;
    end
  end

  // --------------------------------------------------
  // Input drivers, 1 ns after the rising edge
  // --------------------------------------------------
  always @(posedge clk)
  begin
    #1;
    if (reset)
    begin
      dfi_rd_valid = 1'b0;
      dfi_rd_data  = '0;
    end
    else if ((rd_due_q.size() != 0) && (rd_due_q[0] <= cyc))
    begin
      dfi_rd_valid = 1'b1;
      dfi_rd_data  = rd_data_q.pop_front();
      void'(rd_due_q.pop_front());
    end
    else
      dfi_rd_valid = 1'b0;
  end

  // Ready low about 30 % of the time, or held low for the burst test
  always @(posedge clk)
  begin
    #1;
    if (bp_hold)
      resp_ready = 1'b0;
    else
      resp_ready = (($unsigned($random(resp_seed)) % 10) >= 3);
  end

  always @(posedge clk)
  begin
    #1;
    if (!reset && (cyc >= init_at))
      dfi_init_done = 1'b1;
  end

  // Cycle count and run limit
  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (cyc >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run stopped after %0d cycles with %0d responses still missing",
               cyc, exp_data.size());
      $display("sim failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    int errors_before;
    int resp_before;
    req_valid = 1'b0;
    req_bank  = '0;
    req_page  = '0;
    req_word  = '0;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      model_open[b] = 1'b0;
      model_page[b] = '0;
      mem_page[b]   = '0;
    end
    // Init done comes 10 to 30 cycles after the 5 reset cycles
    init_at = 15 + int'($unsigned($random(seed)) % 21);

    @(posedge clk);
    while (reset)
      @(posedge clk);
    #1;

    repeat (NUM_RANDOM)
      random_request(1'b1);
    wait_drain();
    report_test("no commands before init done", err_init);
    report_test("command sequences", err_cmd);
    report_test("phase rule", err_phase);
    report_test("in-order data", err_data);

    errors_before = err_total;
    resp_before   = resp_total;
    bp_hold       = 1'b1;
    @(posedge clk);
    #1;
    fork
      repeat (NUM_BURST)
        random_request(1'b0);
      begin
        repeat (HOLD_CYCLES) @(posedge clk);
        bp_hold = 1'b0;
      end
    join
    wait_drain();
    if (!saw_req_stall)
      $display("Request ready never fell while responses were held back");
    if ((resp_total - resp_before) != NUM_BURST)
      $display("Burst returned %0d responses for %0d requests",
               resp_total - resp_before, NUM_BURST);
    report_test("no loss under back-pressure",
                (err_total - errors_before) + (saw_req_stall ? 0 : 1) +
                (((resp_total - resp_before) == NUM_BURST) ? 0 : 1));

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset source, 8 ns clock with reset held for the first 5 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset drops just after the fifth rising edge
  initial
  begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

/* mmc_sva.sv */
// DFI command protocol and response credit assertions, bound into every mmc_dfi_seq
`timescale 1ns/1ps
`include "mmc_config.svh"

module mmc_sva
  import mmc_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      dfi_init_done,
  input logic      issue_read,
  input logic      dfi_rd_valid,
  input resp_cnt_t resp_count,
  input logic      dfi_cs,
  input logic      dfi_page_phase
);

  logic init_seen;
  logic read_out;

  // Tracks init done and which kind of command sits on the bus
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      init_seen <= 1'b0;
      read_out  <= 1'b0;
    end
    else
    begin
      if (dfi_init_done)
        init_seen <= 1'b1;
      read_out <= issue_read;
    end
  end

  // --------------------------------------------------
  // Protocol properties
  // --------------------------------------------------
  cs_after_init: assert property (@(posedge clk) disable iff (reset)
    dfi_cs |-> init_seen)
    else $error("dfi_cs asserted before DFI init done");

  page_in_page_phase: assert property (@(posedge clk) disable iff (reset)
    (dfi_cs && !read_out) |-> dfi_page_phase)
    else $error("Page command issued in a cache phase");

  read_in_cache_phase: assert property (@(posedge clk) disable iff (reset)
    (dfi_cs && read_out) |-> !dfi_page_phase)
    else $error("Cache read issued in a page phase");

  // Every returned word must find a free response slot
  rd_has_room: assert property (@(posedge clk) disable iff (reset)
    dfi_rd_valid |-> (resp_count < `MMC_RESP_DEPTH))
    else $error("Read data returned into a full response FIFO");

endmodule

bind mmc_dfi_seq mmc_sva sva_i (
  .clk            (clk),
  .reset          (reset),
  .dfi_init_done  (dfi_init_done),
  .issue_read     (issue_read),
  .dfi_rd_valid   (dfi_rd_valid),
  .resp_count     (resp_count),
  .dfi_cs         (dfi_cs),
  .dfi_page_phase (dfi_page_phase)
);

/* mmc_top.sv */
// Memory controller top level, connects the request, command and response paths to the DFI
`timescale 1ns/1ps
`include "mmc_config.svh"

module mmc_top
  import mmc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // Request stream
  input  logic       req_valid,
  input  bank_t      req_bank,
  input  page_t      req_page,
  input  word_t      req_word,
  output logic       req_ready,
  // Response stream
  output logic       resp_valid,
  output data_t      resp_data,
  input  logic       resp_ready,
  // DFI
  input  logic       dfi_init_done,
  output logic       dfi_cs,
  output logic [1:0] dfi_cmd,
  output logic       dfi_page_phase,
  output bank_t      dfi_bank,
  output dram_addr_t dfi_addr,
  input  logic       dfi_rd_valid,
  input  data_t      dfi_rd_data
);

  // Request path
  logic [$bits(bank_t)+$bits(page_t)+$bits(word_t)-1:0] req_head;
  logic                                                 req_full;
  logic                                                 req_head_valid;
  logic                                                 req_pop;
  bank_t                                                head_bank;
  page_t                                                head_page;
  word_t                                                head_word;

  // Command path
  logic [$bits(dram_cmd_e)+$bits(bank_t)+$bits(dram_addr_t)-1:0] cmd_head;
  logic                                                          cmd_full;
  logic                                                          cmd_push;
  logic                                                          cmd_pop;
  logic                                                          cmd_valid;
  dram_cmd_e                                                     gen_kind;
  bank_t                                                         gen_bank;
  dram_addr_t                                                    gen_addr;
  dram_cmd_e                                                     seq_kind;
  bank_t                                                         seq_bank;
  dram_addr_t                                                    seq_addr;

  // Response path
  resp_cnt_t resp_count;

  mmc_page_if page_if ();

  // --------------------------------------------------
  // Request FIFO
  // --------------------------------------------------
  mmc_fifo #(.WIDTH($bits(req_head)), .DEPTH(`MMC_REQ_DEPTH)) req_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .push      (req_valid),
    .push_data ({req_bank, req_page, req_word}),
    .full      (req_full),
    .pop       (req_pop),
    .pop_valid (req_head_valid),
    .pop_data  (req_head),
    .count     ()
  );

  assign req_ready = !req_full;
  assign {head_bank, head_page, head_word} = req_head;

  mmc_page_table page_table_i (
    .clk       (clk),
    .reset     (reset),
    .page_port (page_if)
  );

  mmc_cmd_gen cmd_gen_i (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_head_valid),
    .req_bank  (head_bank),
    .req_page  (head_page),
    .req_word  (head_word),
    .req_pop   (req_pop),
    .page_port (page_if),
    .cmd_full  (cmd_full),
    .cmd_push  (cmd_push),
    .cmd_kind  (gen_kind),
    .cmd_bank  (gen_bank),
    .cmd_addr  (gen_addr)
  );

  // --------------------------------------------------
  // Command FIFO
  // --------------------------------------------------
  mmc_fifo #(.WIDTH($bits(cmd_head)), .DEPTH(`MMC_CMD_DEPTH)) cmd_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .push      (cmd_push),
    .push_data ({gen_kind, gen_bank, gen_addr}),
    .full      (cmd_full),
    .pop       (cmd_pop),
    .pop_valid (cmd_valid),
    .pop_data  (cmd_head),
    .count     ()
  );

  assign seq_kind = dram_cmd_e'(cmd_head[$bits(cmd_head)-1 -: $bits(dram_cmd_e)]);
  assign {seq_bank, seq_addr} = cmd_head[$bits(bank_t)+$bits(dram_addr_t)-1:0];

  mmc_dfi_seq dfi_seq_i (
    .clk            (clk),
    .reset          (reset),
    .dfi_init_done  (dfi_init_done),
    .cmd_valid      (cmd_valid),
    .cmd_kind       (seq_kind),
    .cmd_bank       (seq_bank),
    .cmd_addr       (seq_addr),
    .cmd_pop        (cmd_pop),
    .dfi_rd_valid   (dfi_rd_valid),
    .resp_count     (resp_count),
    .dfi_cs         (dfi_cs),
    .dfi_cmd        (dfi_cmd),
    .dfi_page_phase (dfi_page_phase),
    .dfi_bank       (dfi_bank),
    .dfi_addr       (dfi_addr)
  );

  // --------------------------------------------------
  // Response FIFO, space guaranteed by the read credit
  // --------------------------------------------------
  mmc_fifo #(.WIDTH($bits(data_t)), .DEPTH(`MMC_RESP_DEPTH)) resp_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .push      (dfi_rd_valid),
    .push_data (dfi_rd_data),
    .full      (),
    .pop       (resp_ready),
    .pop_valid (resp_valid),
    .pop_data  (resp_data),
    .count     (resp_count)
  );

endmodule

/* mmc_dfi_seq.sv */
// DFI sequencer, issues queued commands in matching page/cache phases with read credit tracking
`timescale 1ns/1ps
`include "mmc_config.svh"

module mmc_dfi_seq
  import mmc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       dfi_init_done,
  input  logic       cmd_valid,
  input  dram_cmd_e  cmd_kind,
  input  bank_t      cmd_bank,
  input  dram_addr_t cmd_addr,
  output logic       cmd_pop,
  input  logic       dfi_rd_valid,
  input  resp_cnt_t  resp_count,
  output logic       dfi_cs,
  output logic [1:0] dfi_cmd,
  output logic       dfi_page_phase,
  output bank_t      dfi_bank,
  output dram_addr_t dfi_addr
);

  seq_state_e state;
  resp_cnt_t  rd_inflight;
  logic       phase_next;
  logic       read_credit;
  logic       cmd_fits;
  logic       issue;
  logic       issue_read;
  logic [1:0] code;

  // --------------------------------------------------
  // Phase of the cycle the next registered command lands in
  // --------------------------------------------------
  // Low until init done, then toggles every cycle
  assign phase_next = ((state == RUN) || dfi_init_done) && !dfi_page_phase;

  // Every read in flight owns a response FIFO slot
  assign read_credit = (rd_inflight + resp_count) < `MMC_RESP_DEPTH;

  // Page commands in page phase, cache reads in cache phase
  assign cmd_fits   = (cmd_kind == CMD_READ) ? (!phase_next && read_credit) : phase_next;
  assign issue      = (state == RUN) && cmd_valid && cmd_fits;
  assign issue_read = issue && (cmd_kind == CMD_READ);
  assign cmd_pop    = issue;

  always_comb
  begin
    case (cmd_kind)
      CMD_OPEN:  code = `MMC_CODE_OPEN;
      CMD_CLOSE: code = `MMC_CODE_CLOSE;
      default:   code = `MMC_CODE_READ;
    endcase
  end

  // --------------------------------------------------
  // State, phase, chip select and read credit
  // --------------------------------------------------
  // No issue means dfi_cs low, a NOP on the bus
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state          <= WAIT;
      dfi_page_phase <= 1'b0;
      dfi_cs         <= 1'b0;
      rd_inflight    <= '0;
    end
    else
    begin
      if ((state == WAIT) && dfi_init_done)
        state <= RUN;
      dfi_page_phase <= phase_next;
      dfi_cs         <= issue;
      case ({issue_read, dfi_rd_valid})
        2'b10:   rd_inflight <= rd_inflight + 1'b1;
        2'b01:   rd_inflight <= rd_inflight - 1'b1;
        default: rd_inflight <= rd_inflight;
      endcase
    end
  end

  // Command fields, only meaningful while dfi_cs is high
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      dfi_cmd  <= code;
      dfi_bank <= cmd_bank;
      dfi_addr <= cmd_addr;
    end
  end

endmodule

/* mmc_cmd_gen.sv */
// Command generator FSM, turns each queued request into close/open/read commands for the DFI
`timescale 1ns/1ps

module mmc_cmd_gen
  import mmc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req_valid,
  input  bank_t      req_bank,
  input  page_t      req_page,
  input  word_t      req_word,
  output logic       req_pop,
  mmc_page_if.lookup page_port,
  input  logic       cmd_full,
  output logic       cmd_push,
  output dram_cmd_e  cmd_kind,
  output bank_t      cmd_bank,
  output dram_addr_t cmd_addr
);

  cmd_gen_state_e state;
  cmd_gen_state_e state_next;
  logic           page_hit;
  logic           step;

  // Head request hits the page already open in its bank
  assign page_hit = page_port.is_open && page_port.page_match;

  // A command state advances once its command is queued
  assign step = (state != IDLE) && !cmd_full;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= IDLE;
    else
      state <= state_next;
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (req_valid)
        begin
          if (page_hit)
            state_next = READ;
          else if (!page_port.is_open)
            state_next = OPEN;
          else
            state_next = CLOSE;
        end
      end
      CLOSE:   state_next = step ? OPEN : CLOSE;
      OPEN:    state_next = step ? READ : OPEN;
      READ:    state_next = step ? IDLE : READ;
      default: state_next = IDLE;
    endcase
  end

  // --------------------------------------------------
  // Command to queue in the current state
  // --------------------------------------------------
  always_comb
  begin
    cmd_kind = CMD_READ;
    cmd_addr = dram_addr_t'(req_word);
    case (state)
      CLOSE:
      begin
        cmd_kind = CMD_CLOSE;
        cmd_addr = '0;
      end
      OPEN:
      begin
        cmd_kind = CMD_OPEN;
        cmd_addr = req_page;
      end
      default:
      begin
        cmd_kind = CMD_READ;
        cmd_addr = dram_addr_t'(req_word);
      end
    endcase
  end

  assign cmd_push = step;
  assign cmd_bank = req_bank;

  // Request leaves the queue with its cache read
  assign req_pop = (state == READ) && !cmd_full;

  // Table tracks the queued command stream, not the DFI
  assign page_port.bank       = req_bank;
  assign page_port.page       = req_page;
  assign page_port.set_open   = (state == OPEN) && !cmd_full;
  assign page_port.clear_open = (state == CLOSE) && !cmd_full;

endmodule

/* mmc_page_table.sv */
// Per-bank open-page table, looked up and updated by the command generator through mmc_page_if
`timescale 1ns/1ps
`include "mmc_config.svh"

module mmc_page_table
  import mmc_pkg::*;
(
  input logic        clk,
  input logic        reset,
  mmc_page_if.update page_port
);

  logic [(1 << `MMC_BANK_W)-1:0] open_flag;
  page_t                         open_page [1 << `MMC_BANK_W];

  // --------------------------------------------------
  // Lookup for the addressed bank
  // --------------------------------------------------
  assign page_port.is_open = open_flag[page_port.bank];

  // Plain page compare, qualified with is_open by the generator
  assign page_port.page_match = (open_page[page_port.bank] == page_port.page);

  // --------------------------------------------------
  // Update on the generator strobes
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      open_flag <= '0;
      for (int b = 0; b < (1 << `MMC_BANK_W); b++)
        open_page[b] <= '0;
    end
    else if (page_port.set_open)
    begin
      open_flag[page_port.bank] <= 1'b1;
      open_page[page_port.bank] <= page_port.page;
    end
    else if (page_port.clear_open)
    begin
      // Page id kept, only the flag matters once closed
      open_flag[page_port.bank] <= 1'b0;
    end
  end

endmodule

/* mmc_fifo.sv */
// Synchronous first-word-fall-through FIFO, used for the request, command and response queues
`timescale 1ns/1ps

module mmc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       push,
  input  logic [WIDTH-1:0]           push_data,
  output logic                       full,
  input  logic                       pop,
  output logic                       pop_valid,
  output logic [WIDTH-1:0]           pop_data,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic             do_push;
  logic             do_pop;
  logic [CW-1:0]    count_next;

  // Pointer advance with wrap for any depth
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign do_push    = push && !full;
  assign do_pop     = pop && pop_valid;
  assign pop_valid  = (count != '0);
  assign pop_data   = mem[rd_ptr];
  assign count_next = count + CW'(do_push) - CW'(do_pop);

  // Storage
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // Pointers and fill level
  // Full is held during reset so no producer writes while the queue is cleared
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b1;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count_next;
      full  <= (count_next == CW'(DEPTH));
    end
  end

endmodule

/* mmc_page_if.sv */
// Open-page table port between the command generator and the table, one instance in the top level
`timescale 1ns/1ps

interface mmc_page_if
  import mmc_pkg::*;
();

  // Address presented for lookup and update
  bank_t bank;
  page_t page;

  // Lookup results, combinational
  logic is_open;
  logic page_match;

  // Update strobes, take effect on the next edge
  logic set_open;
  logic clear_open;

  // Command generator side
  modport lookup (
    output bank, page, set_open, clear_open,
    input  is_open, page_match
  );

  // Table side
  modport update (
    input  bank, page, set_open, clear_open,
    output is_open, page_match
  );

endinterface

/* mmc_pkg.sv */
// Shared address, data and state types for the memory controller; import with mmc_pkg::*
`include "mmc_config.svh"

package mmc_pkg;

  // Address fields of a request
  typedef logic [`MMC_BANK_W-1:0] bank_t;
  typedef logic [`MMC_PAGE_W-1:0] page_t;
  typedef logic [`MMC_WORD_W-1:0] word_t;

  // DFI address bus, carries a page or a zero-extended word
  typedef logic [`MMC_PAGE_W-1:0] dram_addr_t;

  // One read data word
  typedef logic [`MMC_DATA_W-1:0] data_t;

  // Response FIFO fill level, 0 up to the full depth
  typedef logic [$clog2(`MMC_RESP_DEPTH + 1)-1:0] resp_cnt_t;

  // Commands held in the command FIFO
  typedef enum logic [1:0] {
    CMD_OPEN,
    CMD_CLOSE,
    CMD_READ
  } dram_cmd_e;

  // Command generator FSM
  typedef enum logic [1:0] {
    IDLE,
    CLOSE,
    OPEN,
    READ
  } cmd_gen_state_e;

  // DFI sequencer FSM
  typedef enum logic {
    WAIT,
    RUN
  } seq_state_e;

endpackage

/* mmc_config.svh */
// Controller widths, FIFO depths and DFI command codes; include wherever a macro is needed
`ifndef MMC_CONFIG_SVH
`define MMC_CONFIG_SVH

// --------------------------------------------------
// DRAM address and data widths
// --------------------------------------------------
`define MMC_BANK_W 3
`define MMC_PAGE_W 12
`define MMC_WORD_W 6
`define MMC_DATA_W 32

// --------------------------------------------------
// FIFO depths
// --------------------------------------------------
`define MMC_REQ_DEPTH 4
`define MMC_CMD_DEPTH 8
`define MMC_RESP_DEPTH 8

// --------------------------------------------------
// DFI command codes
// --------------------------------------------------
// Close and read share a code, the phase tells them apart
`define MMC_CODE_OPEN 2'b11
`define MMC_CODE_CLOSE 2'b10
`define MMC_CODE_READ 2'b10

`endif
